//--- Makefile
TOP := axil_sram_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f axil_sram.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f axil_sram.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- axil_sram.f
source/axil_pkg.sv
source/sram_pkg.sv
source/resp_slot.sv
source/axil_sram_if_rd.sv
source/axil_sram_if_wr.sv
source/sram_arbiter_fsm.sv
source/sram_access_timer.sv
source/sram_bank.sv
source/axil_sram_top.sv
test/axil_sram_properties.sv
test/axil_sram_tb.sv

//--- source/axil_pkg.sv
package axil_pkg;

  // byte address seen on the AXI-Lite bus
  localparam int axil_addr_width = 12;

  localparam int axil_data_width = 32;

  // one strobe bit per data byte
  localparam int axil_strb_width = axil_data_width / 8;

  // address bits that select a byte inside one word
  localparam int addr_lsb = $clog2(axil_strb_width);

  // response code carried on rresp and bresp
  typedef logic [1:0] resp_t;

  // the bank never fails, so OKAY is the only code ever returned
  localparam resp_t resp_okay = 2'b00;

endpackage

//--- source/axil_sram_if_rd.sv
`timescale 1ns/1ns

module axil_sram_if_rd (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                arvalid,
  input  logic [axil_pkg::axil_addr_width-1:0] araddr,
  output logic                                arready,
  output logic                                rvalid,
  input  logic                                rready,
  output sram_pkg::word_t                     rdata,
  output logic [1:0]                          rresp,
  output logic                                rd_req,
  input  logic                                rd_grant,
  output logic [sram_pkg::sram_addr_width-1:0] rd_addr,
  input  logic                                access_done,
  input  sram_pkg::word_t                     bank_rdata
);
  import axil_pkg::*;
  import sram_pkg::*;

  logic rd_pending;
  logic slot_full;

  // set on the AR handshake, so a write's access_done is not taken for ours
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pending <= 1'b0;
    end else if (rd_grant) begin
      rd_pending <= 1'b1;
    end else if (access_done) begin
      rd_pending <= 1'b0;
    end
  end

  // hold off while the previous read data has not been taken
  assign rd_req  = arvalid && !slot_full && !rd_pending;
  assign arready = rd_grant;
  assign rd_addr = araddr[axil_addr_width-1:addr_lsb];

  resp_slot #(
    .payload_t(word_t)
  ) i_r_slot (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (access_done && rd_pending),
    .load_data(bank_rdata),
    .valid    (rvalid),
    .ready    (rready),
    .data     (rdata),
    .full     (slot_full)
  );

  assign rresp = resp_okay;

endmodule

//--- source/axil_sram_if_wr.sv
`timescale 1ns/1ns

module axil_sram_if_wr (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 awvalid,
  input  logic [axil_pkg::axil_addr_width-1:0] awaddr,
  output logic                                 awready,
  input  logic                                 wvalid,
  input  sram_pkg::word_t                      wdata,
  input  sram_pkg::strb_t                      wstrb,
  output logic                                 wready,
  output logic                                 bvalid,
  input  logic                                 bready,
  output axil_pkg::resp_t                      bresp,
  output logic                                 wr_req,
  input  logic                                 wr_grant,
  output logic [sram_pkg::sram_addr_width-1:0] wr_addr,
  output sram_pkg::word_t                      wr_data,
  output sram_pkg::strb_t                      wr_strb,
  input  logic                                 access_done
);
  import axil_pkg::*;
  import sram_pkg::*;

  logic wr_pending;
  logic slot_full;

  // marks our own write between the handshake and the end of the access
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_pending <= 1'b0;
    end else if (wr_grant) begin
      wr_pending <= 1'b1;
    end else if (access_done) begin
      wr_pending <= 1'b0;
    end
  end

  // address and data must both be present, the bank takes them as one command
  assign wr_req = awvalid && wvalid && !slot_full && !wr_pending;

  // both channels are accepted on the same edge
  assign awready = wr_grant;
  assign wready  = wr_grant;

  // payloads are stable until the handshake, so they feed the bank directly
  assign wr_addr = awaddr[axil_addr_width-1:addr_lsb];
  assign wr_data = wdata;
  assign wr_strb = wstrb;

  resp_slot #(
    .payload_t(resp_t)
  ) i_b_slot (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (access_done && wr_pending),
    .load_data(resp_okay),
    .valid    (bvalid),
    .ready    (bready),
    .data     (bresp),
    .full     (slot_full)
  );

endmodule

//--- source/axil_sram_top.sv
`timescale 1ns/1ns

module axil_sram_top (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 arvalid,
  output logic                                 arready,
  input  logic [axil_pkg::axil_addr_width-1:0] araddr,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic [axil_pkg::axil_data_width-1:0] rdata,
  output logic [1:0]                           rresp,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [axil_pkg::axil_addr_width-1:0] awaddr,
  input  logic                                 wvalid,
  output logic                                 wready,
  input  logic [axil_pkg::axil_data_width-1:0] wdata,
  input  logic [axil_pkg::axil_strb_width-1:0] wstrb,
  output logic                                 bvalid,
  input  logic                                 bready,
  output axil_pkg::resp_t                      bresp
);
  import sram_pkg::*;

  logic                       rd_req;
  logic                       wr_req;
  logic                       rd_grant;
  logic                       wr_grant;
  logic                       timer_start;
  logic                       access_done;
  logic [sram_addr_width-1:0] rd_addr;
  logic [sram_addr_width-1:0] wr_addr;
  word_t                      wr_data;
  strb_t                      wr_strb;
  word_t                      bank_rdata;
  logic                       bank_en;
  logic                       bank_we;
  logic [sram_addr_width-1:0] bank_addr;

  axil_sram_if_rd i_if_rd (
    .clk        (clk),
    .rst_n      (rst_n),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arready    (arready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rd_req     (rd_req),
    .rd_grant   (rd_grant),
    .rd_addr    (rd_addr),
    .access_done(access_done),
    .bank_rdata (bank_rdata)
  );

  axil_sram_if_wr i_if_wr (
    .clk        (clk),
    .rst_n      (rst_n),
    .awvalid    (awvalid),
    .awaddr     (awaddr),
    .awready    (awready),
    .wvalid     (wvalid),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .wr_req     (wr_req),
    .wr_grant   (wr_grant),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_strb    (wr_strb),
    .access_done(access_done)
  );

  sram_arbiter_fsm i_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_req     (rd_req),
    .wr_req     (wr_req),
    .access_done(access_done),
    .rd_grant   (rd_grant),
    .wr_grant   (wr_grant),
    .timer_start(timer_start)
  );

  sram_access_timer i_timer (
    .clk  (clk),
    .rst_n(rst_n),
    .start(timer_start),
    .done (access_done)
  );

  // grants are one-hot, so the write side only has to steer the address
  assign bank_en   = rd_grant || wr_grant;
  assign bank_we   = wr_grant;
  assign bank_addr = wr_grant ? wr_addr : rd_addr;

  sram_bank i_bank (
    .clk  (clk),
    .en   (bank_en),
    .we   (bank_we),
    .addr (bank_addr),
    .wdata(wr_data),
    .strb (wr_strb),
    .rdata(bank_rdata)
  );

endmodule

//--- source/resp_slot.sv
`timescale 1ns/1ns

module resp_slot #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  payload_t load_data,
  output logic     valid,
  input  logic     ready,
  output payload_t data,
  output logic     full
);

  // the valid flag is the only control state here
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (valid && ready) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data <= load_data;
    end
  end

  // the owner must not start another access while a response waits here
  assign full = valid;

endmodule

//--- source/sram_access_timer.sv
`timescale 1ns/1ns

module sram_access_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  output logic done
);
  import sram_pkg::*;

  localparam int cnt_width = $clog2(access_cycles + 1);

  logic [cnt_width-1:0] cnt;

  // done is registered when the count passes one, which puts it exactly
  // access_cycles edges after start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= (cnt == cnt_width'(1));
      if (start) begin
        cnt <= cnt_width'(access_cycles);
      end else if (cnt != '0) begin
        cnt <= cnt - cnt_width'(1);
      end
    end
  end

endmodule

//--- source/sram_arbiter_fsm.sv
`timescale 1ns/1ns

module sram_arbiter_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic rd_req,
  input  logic wr_req,
  input  logic access_done,
  output logic rd_grant,
  output logic wr_grant,
  output logic timer_start
);

  typedef enum logic [1:0] {
    st_idle,
    st_rd_busy,
    st_wr_busy
  } state_t;

  state_t state;
  state_t state_next;
  logic   pick_rd;
  logic   pick_wr;

  // remembers which channel won last, for turn taking on a tie
  logic   last_rd;

  // a read wins when alone, or on a tie when the write went last
  assign pick_rd = (state == st_idle) && rd_req && (!wr_req || !last_rd);
  assign pick_wr = (state == st_idle) && wr_req && !pick_rd;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (pick_rd) begin
          state_next = st_rd_busy;
        end else if (pick_wr) begin
          state_next = st_wr_busy;
        end
      end
      st_rd_busy, st_wr_busy: begin
        if (access_done) begin
          state_next = st_idle;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  // grants are one-cycle pulses, the busy states cover the rest of the access
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= st_idle;
      rd_grant <= 1'b0;
      wr_grant <= 1'b0;
      last_rd  <= 1'b0;
    end else begin
      state    <= state_next;
      rd_grant <= pick_rd;
      wr_grant <= pick_wr;
      if (pick_rd || pick_wr) begin
        last_rd <= pick_rd;
      end
    end
  end

  // the bank command goes out in the grant cycle, so timing starts there too
  assign timer_start = rd_grant || wr_grant;

endmodule

//--- source/sram_bank.sv
`timescale 1ns/1ns

module sram_bank (
  input  logic                                 clk,
  input  logic                                 en,
  input  logic                                 we,
  input  logic [sram_pkg::sram_addr_width-1:0] addr,
  input  sram_pkg::word_t                      wdata,
  input  sram_pkg::strb_t                      strb,
  output sram_pkg::word_t                      rdata
);
  import sram_pkg::*;

  localparam int num_bytes = $bits(strb_t);

  word_t mem [sram_words];

  // single port, the arbiter guarantees one command per access
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        for (int i = 0; i < num_bytes; i++) begin
          if (strb[i]) begin
            mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
          end
        end
      end else begin
        // read data stays put until the next read command
        rdata <= mem[addr];
      end
    end
  end

endmodule

//--- source/sram_pkg.sv
package sram_pkg;

  // word address into the bank
  localparam int sram_addr_width = 10;

  localparam int sram_words = 1 << sram_addr_width;

  localparam int sram_data_width = 32;

  // number of wait cycles that one bank access occupies
  localparam int access_cycles = 2;

  // one storage word of the bank
  typedef logic [sram_data_width-1:0] word_t;

  // byte enables for a partial write
  typedef logic [sram_data_width/8-1:0] strb_t;

endpackage

//--- test/axil_sram_properties.sv
`timescale 1ns/1ns

module axil_sram_properties (
  input logic                                 clk,
  input logic                                 rst_n,
  input logic                                 arready,
  input logic                                 awready,
  input logic                                 rvalid,
  input logic                                 rready,
  input logic [axil_pkg::axil_data_width-1:0] rdata,
  input logic                                 bvalid,
  input logic                                 bready
);

  // number of failed properties, the testbench adds it to its own counts
  int fail_count = 0;

  r_held: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      fail_count++;
      $error("rvalid or rdata changed before rready");
    end

  b_held: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  // the bank port is granted to one channel at a time
  one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    !(arready && awready))
    else begin
      fail_count++;
      $error("arready and awready are high together");
    end

  r_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    !(arready && rvalid && !rready))
    else begin
      fail_count++;
      $error("arready is high while a read response is stalled");
    end

endmodule

bind axil_sram_top axil_sram_properties i_properties (
  .clk    (clk),
  .rst_n  (rst_n),
  .arready(arready),
  .awready(awready),
  .rvalid (rvalid),
  .rready (rready),
  .rdata  (rdata),
  .bvalid (bvalid),
  .bready (bready)
);

//--- test/axil_sram_tb.sv
`timescale 1ns/1ns

module axil_sram_tb;
  import axil_pkg::*;
  import sram_pkg::*;

  localparam int num_random = 40;
  localparam int num_pairs = 6;
  localparam int max_stall = 8;
  localparam int num_ops = 2 * num_random + 4 + 3 * num_pairs;
  localparam int watchdog_ns = num_ops * (2 * access_cycles + 4 + max_stall) * 4 + 400;
  localparam int kind_value = 0;
  localparam int kind_latency = 1;
  localparam int kind_protocol = 2;

  logic clk;
  logic rst_n;
  logic arvalid, arready, rvalid, rready;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic [axil_addr_width-1:0] araddr;
  logic [axil_addr_width-1:0] awaddr;
  word_t rdata;
  word_t wdata;
  strb_t wstrb;
  logic [1:0] rresp;
  resp_t bresp;

  // reference copy of the bank, updated on every accepted write
  word_t model [sram_words];
  logic [15:0] lfsr_state;
  // mirrors the arbiter's memory of the channel served last
  logic last_was_read;
  word_t rd_expect;
  int value_errs;
  int latency_errs;
  int protocol_errs;

  axil_sram_top i_dut (.*);

  always #2 clk = ~clk;

  initial begin
    #(watchdog_ns);
    $display("watchdog expired at %0t ns, the run hung before all tests finished", $time);
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic void note_fail(input int kind, input string what);
    case (kind)
      kind_value:   value_errs++;
      kind_latency: latency_errs++;
      default:      protocol_errs++;
    endcase
    $display("[FAIL] %0t: %s", $time, what);
  endfunction

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_step()};
    end
    return value;
  endfunction

  function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                        input strb_t strb);
    word_t result;
    result = old_word;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  // called on a falling edge, returns on the falling edge after the AR transfer
  task automatic send_ar(input logic [axil_addr_width-1:0] addr);
    arvalid = 1'b1;
    araddr = addr;
    while (!arready) @(negedge clk);
    last_was_read = 1'b1;
    rd_expect = model[addr[axil_addr_width-1:addr_lsb]];
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  task automatic take_r(input int stall, input logic check_latency);
    int edges;
    word_t held;
    edges = 0;
    while (!rvalid) begin
      @(negedge clk);
      edges++;
    end
    if (check_latency) begin
      assert (edges == access_cycles + 1)
        else note_fail(kind_latency, $sformatf("rvalid came %0d edges after AR", edges));
    end
    held = rdata;
    assert (rdata == rd_expect)
      else note_fail(kind_value, $sformatf("rdata %h, expected %h", rdata, rd_expect));
    assert (rresp == resp_okay)
      else note_fail(kind_value, $sformatf("rresp %b, expected OKAY", rresp));
    repeat (stall) begin
      @(negedge clk);
      assert (rvalid && rdata == held)
        else note_fail(kind_protocol, "rvalid or rdata changed while rready was low");
    end
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic send_w(input logic [axil_addr_width-1:0] addr, input word_t data,
                        input strb_t strb);
    awvalid = 1'b1;
    wvalid = 1'b1;
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    while (!awready) @(negedge clk);
    assert (wready)
      else note_fail(kind_protocol, "awready rose without wready");
    last_was_read = 1'b0;
    model[addr[axil_addr_width-1:addr_lsb]] =
      merge_bytes(model[addr[axil_addr_width-1:addr_lsb]], data, strb);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
  endtask

  task automatic take_b(input int stall, input logic check_latency);
    int edges;
    edges = 0;
    while (!bvalid) begin
      @(negedge clk);
      edges++;
    end
    if (check_latency) begin
      assert (edges == access_cycles + 1)
        else note_fail(kind_latency, $sformatf("bvalid came %0d edges after AW/W", edges));
    end
    assert (bresp == resp_okay)
      else note_fail(kind_value, $sformatf("bresp %b, expected OKAY", bresp));
    repeat (stall) begin
      @(negedge clk);
      assert (bvalid)
        else note_fail(kind_protocol, "bvalid dropped while bready was low");
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  // the read uses its own low address bits, so byte aliasing is covered too
  task automatic run_random_ops();
    logic [sram_addr_width-1:0] word;
    logic [addr_lsb-1:0] lo_w;
    logic [addr_lsb-1:0] lo_r;
    word_t data;
    strb_t strb;
    logic do_write;
    for (int i = 0; i < num_random; i++) begin
      word = sram_addr_width'(random_bits(sram_addr_width));
      lo_w = addr_lsb'(random_bits(addr_lsb));
      lo_r = addr_lsb'(random_bits(addr_lsb));
      data = random_bits(32);
      strb = strb_t'(random_bits($bits(strb_t)));
      do_write = random_bits(2) != 32'd0;
      if (do_write) begin
        send_w({word, lo_w}, data, strb);
        take_b(int'(random_bits(2)), 1'b1);
      end
      send_ar({word, lo_r});
      take_r(int'(random_bits(2)), 1'b1);
    end
  endtask

  task automatic run_stall_test();
    send_w({10'h015, 2'b11}, random_bits(32), 4'hf);
    take_b(0, 1'b1);
    send_ar({10'h015, 2'b00});
    fork
      take_r(max_stall, 1'b1);
      begin
        // a second read waits behind the full slot, the write goes ahead
        while (!rvalid) @(negedge clk);
        arvalid = 1'b1;
        araddr = {10'h016, 2'b01};
        send_w({10'h3f0, 2'b10}, random_bits(32), strb_t'(random_bits(4)));
        take_b(0, 1'b1);
      end
      begin
        while (!rvalid) @(negedge clk);
        repeat (max_stall) begin
          assert (!arready)
            else note_fail(kind_protocol, "AR was accepted while the R slot was full");
          @(negedge clk);
        end
      end
    join
    send_ar({10'h016, 2'b01});
    take_r(0, 1'b1);
  endtask

  // each pair leaves its loser as the last served, so a lone access in
  // between sets up the turn and the winner alternates from pair to pair
  task automatic run_pair_test();
    logic [sram_addr_width-1:0] word;
    logic rd_first;
    for (int i = 0; i < num_pairs; i++) begin
      word = sram_addr_width'(random_bits(sram_addr_width));
      if (i % 2 == 0) begin
        send_w({word, 2'b00}, random_bits(32), 4'hf);
        take_b(0, 1'b1);
      end else begin
        send_ar({word, 2'b00});
        take_r(0, 1'b1);
      end
      rd_first = !last_was_read;
      fork
        begin
          send_ar({word, 2'b10});
          take_r(0, 1'b0);
        end
        begin
          send_w({~word[sram_addr_width-1], word[sram_addr_width-2:0], 2'b00},
                 random_bits(32), strb_t'(random_bits(4)));
          take_b(0, 1'b0);
        end
        begin
          @(negedge clk);
          assert (arready == rd_first && awready == !rd_first)
            else note_fail(kind_protocol, "the wrong channel won a simultaneous request");
        end
      join
    end
  endtask

  initial begin
    int total;
    clk = 1'b0;
    rst_n = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    lfsr_state = 16'd15414;
    last_was_read = 1'b0;
    rd_expect = '0;
    value_errs = 0;
    latency_errs = 0;
    protocol_errs = 0;
    for (int i = 0; i < sram_words; i++) begin
      model[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (!arready && !awready && !wready && !rvalid && !bvalid)
      else note_fail(kind_protocol, "a ready or valid output is high after reset");
    run_random_ops();
    run_stall_test();
    run_pair_test();
    total = value_errs + latency_errs + protocol_errs + i_dut.i_properties.fail_count;
    $display("errors: value %0d, latency %0d, protocol %0d, assertion %0d",
             value_errs, latency_errs, protocol_errs, i_dut.i_properties.fail_count);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
